// ==== Bender.yml ====
package:
  name: lenet_c1s2

sources:
  - lenet_pkg.sv
  - line_buffer.sv
  - stream_control.sv
  - conv_kernel.sv
  - max_pool.sv
  - lenet_c1s2.sv
  - target: simulation
    files:
      - lenet_c1s2_assertions.sv
      - tb_lenet_c1s2.sv

// ==== conv_kernel.sv ====
`timescale 1ns/1ns

module conv_kernel (
	input  logic                clk,
	input  lenet_pkg::pixel_t   column [lenet_pkg::KERNEL_SIZE],  // newest row last
	input  lenet_pkg::kernel_t  weights,
	input  lenet_pkg::pixel_t   bias,
	output lenet_pkg::feature_t c1_out
);
	import lenet_pkg::*;

	// four earlier columns, index 0 is the oldest
	pixel_t   hist [KERNEL_SIZE][KERNEL_SIZE-1];
	pixel_t   win  [KERNEL_SIZE][KERNEL_SIZE];  // full window, last column is the live input
	feature_t acc;
	feature_t relu;

	// shift window left by one column every clock
	always_ff @(posedge clk) begin
		for (int r = 0; r < KERNEL_SIZE; r++) begin
			for (int c = 0; c < KERNEL_SIZE-2; c++) begin
				hist[r][c] <= hist[r][c+1];
			end
			hist[r][KERNEL_SIZE-2] <= column[r];
		end
	end

	always_comb begin
		for (int r = 0; r < KERNEL_SIZE; r++) begin
			for (int c = 0; c < KERNEL_SIZE-1; c++) begin
				win[r][c] = hist[r][c];
			end
			win[r][KERNEL_SIZE-1] = column[r];  // incoming column completes the window
		end
	end

	// 25 products plus bias, everything wraps at 16 bits
	always_comb begin
		acc = feature_t'(bias);  // sign-extended
		for (int r = 0; r < KERNEL_SIZE; r++) begin
			for (int c = 0; c < KERNEL_SIZE; c++) begin
				// 8x8 product always fits the 16-bit signed range
				acc = acc + feature_t'(win[r][c]) * feature_t'(weights[r*KERNEL_SIZE+c]);
			end
		end
	end

	assign relu = acc[HALF_WIDTH-1] ? '0 : acc;  // clamp negatives

	// output register, one cycle after the window-completing pixel
	always_ff @(posedge clk) begin
		c1_out <= relu;
	end

endmodule

// ==== files.f ====
lenet_pkg.sv
line_buffer.sv
stream_control.sv
conv_kernel.sv
max_pool.sv
lenet_c1s2.sv
lenet_c1s2_assertions.sv
tb_lenet_c1s2.sv

// ==== kernel_c1.mem ====
// one line per c1 map: 25 weights, row-major from the top left, then the bias
// signed 8-bit two's complement hex
01 02 03 02 01 02 04 06 04 02 03 06 09 06 03 02 04 06 04 02 01 02 03 02 01 10
ff fe 00 02 01 fd fa 00 06 03 fc f8 00 08 04 fd fa 00 06 03 ff fe 00 02 01 f0
02 04 06 04 02 01 02 03 02 01 00 00 00 00 00 ff fe fd fe ff fe fc fa fc fe 05
7f 80 7f 80 7f 80 7f 80 7f 80 7f 80 7f 80 7f 80 7f 80 7f 80 7f 80 7f 80 7f 7f
f8 f9 fa fb fc fd fe ff f8 f9 fa fb fc fd fe ff f8 f9 fa fb fc fd fe ff f8 80
13 e5 2a 07 c1 5d 0b f2 33 a8 1c 66 d4 09 ee 41 b7 25 0e 9c 58 e1 3f c6 17 2c

// ==== lenet_c1s2.sv ====
`timescale 1ns/1ns

module lenet_c1s2 (
	input  logic                clk,
	input  logic                rst,
	input  lenet_pkg::pixel_t   pixel,                          // one pixel per clock
	output lenet_pkg::feature_t pool_out [lenet_pkg::C1_MAPS],  // s2 values, one per map
	output logic                pool_valid                      // one-cycle strobe
);
	import lenet_pkg::*;

	// per map: 25 weights then the bias
	pixel_t kernel_mem [C1_MAPS*(KERNEL_TAPS+1)];
	pixel_t row_taps [KERNEL_SIZE-1];  // same column, 1..4 rows back
	pixel_t window_col [KERNEL_SIZE];  // top row first, live pixel last
	logic   c1_valid;
	logic   pool_phase;

	initial begin
		$readmemh("kernel_c1.mem", kernel_mem);
	end

	// four image rows of history, shifting on every pixel
	line_buffer #(
		.COLS   (IMAGE_COLS),
		.ROWS   (KERNEL_SIZE-1),
		.data_t (pixel_t)
	) u_pix_rows (
		.clk  (clk),
		.rst  (rst),
		.en   (1'b1),
		.din  (pixel),
		.dout (row_taps)
	);

	for (genvar r = 0; r < KERNEL_SIZE-1; r++) begin : g_col
		assign window_col[r] = row_taps[KERNEL_SIZE-2-r];  // oldest row on top
	end
	assign window_col[KERNEL_SIZE-1] = pixel;

	stream_control u_ctrl (
		.clk        (clk),
		.rst        (rst),
		.c1_valid   (c1_valid),
		.pool_phase (pool_phase)
	);

	// c1 kernel and s2 pool for each feature map
	for (genvar g = 0; g < C1_MAPS; g++) begin : g_map
		kernel_t  weights;
		feature_t c1_val;

		for (genvar t = 0; t < KERNEL_TAPS; t++) begin : g_tap
			assign weights[t] = kernel_mem[g*(KERNEL_TAPS+1)+t];
		end

		conv_kernel u_conv (
			.clk     (clk),
			.column  (window_col),
			.weights (weights),
			.bias    (kernel_mem[g*(KERNEL_TAPS+1)+KERNEL_TAPS]),
			.c1_out  (c1_val)
		);

		max_pool u_pool (
			.clk        (clk),
			.rst        (rst),
			.c1_valid   (c1_valid),
			.pool_phase (pool_phase),
			.c1_in      (c1_val),
			.pool_out   (pool_out[g])
		);
	end

	// pools register on pool_phase, so the strobe trails it by one cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			pool_valid <= 1'b0;
		end else begin
			pool_valid <= pool_phase;
		end
	end

endmodule

// ==== lenet_c1s2_assertions.sv ====
`timescale 1ns/1ns

module lenet_c1s2_assertions (
	input logic                clk,
	input logic                rst,
	input logic                c1_valid,
	input logic                pool_valid,
	input lenet_pkg::feature_t pool_out [lenet_pkg::C1_MAPS]
);
	import lenet_pkg::*;

	// strobe is a single-cycle pulse, pooling blocks are two columns apart
	single_pulse: assert property (@(posedge clk) disable iff (rst) pool_valid |=> !pool_valid)
		else $error("pool_valid high in two consecutive cycles");

	// a pool result always follows a valid c1 position
	after_c1: assert property (@(posedge clk) disable iff (rst) pool_valid |-> $past(c1_valid))
		else $error("pool_valid without c1_valid one cycle earlier");

	known_strobe: assert property (@(posedge clk) disable iff (rst) !$isunknown(pool_valid))
		else $error("pool_valid unknown after reset");

	// relu before pooling, so no output can be negative
	for (genvar g = 0; g < C1_MAPS; g++) begin : g_sign
		non_negative: assert property (@(posedge clk) disable iff (rst)
			pool_valid |-> !pool_out[g][HALF_WIDTH-1])
			else $error("pool_out[%0d] negative while pool_valid", g);
	end

endmodule

// ==== lenet_pkg.sv ====
package lenet_pkg;

	// input image, one signed pixel per clock in raster order
	localparam int IMAGE_COLS = 32;
	localparam int IMAGE_ROWS = 32;

	// c1 convolution window
	localparam int KERNEL_SIZE = 5;
	localparam int KERNEL_TAPS = KERNEL_SIZE * KERNEL_SIZE;  // weights per map, bias not counted

	localparam int C1_SIZE = IMAGE_COLS - KERNEL_SIZE + 1;  // 28
	localparam int S2_SIZE = C1_SIZE / 2;                    // 14 after 2x2 stride-2 pooling
	localparam int C1_MAPS = 6;

	localparam int PIXEL_WIDTH = 8;   // pixels and weights
	localparam int HALF_WIDTH  = 16;  // c1 and s2 values, sums wrap at this width

	typedef logic signed [PIXEL_WIDTH-1:0] pixel_t;
	typedef logic signed [HALF_WIDTH-1:0]  feature_t;

	// weights of one map, row-major, tap 0 is top left of the window
	typedef pixel_t kernel_t [KERNEL_TAPS];

	// image position counters
	typedef logic [$clog2(IMAGE_COLS)-1:0] col_t;
	typedef logic [$clog2(IMAGE_ROWS)-1:0] row_t;

endpackage

// ==== line_buffer.sv ====
`timescale 1ns/1ns

module line_buffer #(
	parameter int  COLS   = 32,          // entries per row
	parameter int  ROWS   = 4,           // number of delayed rows
	parameter type data_t = logic [7:0]
) (
	input  logic  clk,
	input  logic  rst,
	input  logic  en,              // shift strobe, one per stream element
	input  data_t din,
	output data_t dout [ROWS]      // dout[k] is din from k+1 rows back
);

	// one long shift chain, entry 0 is the newest element
	data_t chain [ROWS*COLS];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < ROWS*COLS; i++) begin
				chain[i] <= '0;  // first frame sees zeros above row 0
			end
		end else if (en) begin
			chain[0] <= din;
			for (int i = 1; i < ROWS*COLS; i++) begin
				chain[i] <= chain[i-1];
			end
		end
	end

	// tap at the end of each row segment, exactly (k+1)*COLS shifts old
	for (genvar k = 0; k < ROWS; k++) begin : g_row_tap
		assign dout[k] = chain[(k+1)*COLS-1];
	end

endmodule

// ==== max_pool.sv ====
`timescale 1ns/1ns

module max_pool (
	input  logic                clk,
	input  logic                rst,
	input  logic                c1_valid,    // c1_in is a real c1 value
	input  logic                pool_phase,  // c1_in closes a 2x2 block
	input  lenet_pkg::feature_t c1_in,
	output lenet_pkg::feature_t pool_out
);
	import lenet_pkg::*;

	feature_t above [1];   // same column, one c1 row up
	feature_t prev_cur;    // previous column, current row
	feature_t prev_up;     // previous column, row above
	feature_t max_cur;
	feature_t max_up;
	feature_t max_all;

	// c1 row buffer only advances on valid c1 positions
	line_buffer #(
		.COLS   (C1_SIZE),
		.ROWS   (1),
		.data_t (feature_t)
	) u_c1_row (
		.clk  (clk),
		.rst  (rst),
		.en   (c1_valid),
		.din  (c1_in),
		.dout (above)
	);

	always_ff @(posedge clk) begin
		if (c1_valid) begin
			prev_cur <= c1_in;
			prev_up  <= above[0];
		end
	end

	// max of the four values in two stages
	assign max_cur = (c1_in > prev_cur) ? c1_in : prev_cur;
	assign max_up  = (above[0] > prev_up) ? above[0] : prev_up;
	assign max_all = (max_cur > max_up) ? max_cur : max_up;

	always_ff @(posedge clk) begin
		if (pool_phase) begin
			pool_out <= max_all;  // held until the next block closes
		end
	end

endmodule

// ==== stream_control.sv ====
`timescale 1ns/1ns

module stream_control (
	input  logic clk,
	input  logic rst,
	output logic c1_valid,    // kernel outputs hold a complete 5x5 window
	output logic pool_phase   // c1 value closes a 2x2 pooling block
);
	import lenet_pkg::*;

	col_t col;         // position of the pixel sampled at the coming edge
	row_t row;
	logic win_full;    // that pixel is the bottom right of a full window
	logic odd_pos;

	assign win_full = (col >= col_t'(KERNEL_SIZE-1)) && (row >= row_t'(KERNEL_SIZE-1));

	// c1 index is image index minus 4, parity is the same
	assign odd_pos = col[0] & row[0];

	// raster counters, frames run back to back with no gap
	always_ff @(posedge clk) begin
		if (rst) begin
			col <= '0;
			row <= '0;
		end else if (col == col_t'(IMAGE_COLS-1)) begin
			col <= '0;
			if (row == row_t'(IMAGE_ROWS-1)) begin
				row <= '0;  // frame end
			end else begin
				row <= row + 1'b1;
			end
		end else begin
			col <= col + 1'b1;
		end
	end

	// registered so the strobes line up with the kernels' output register
	always_ff @(posedge clk) begin
		if (rst) begin
			c1_valid   <= 1'b0;
			pool_phase <= 1'b0;
		end else begin
			c1_valid   <= win_full;
			pool_phase <= win_full & odd_pos;  // odd c1 row and odd c1 column
		end
	end

endmodule

// ==== tb_lenet_c1s2.sv ====
`timescale 1ns/1ns

module tb_lenet_c1s2;
	import lenet_pkg::*;

	typedef enum int {kind_const, kind_ramp, kind_random, kind_neg} pattern_e;

	typedef struct {
		string    name;
		pattern_e kind;
		int       value;   // constant, ramp offset or negative base
		int       pulses;  // pool_valid pulses expected per frame
	} test_row_t;

	localparam int NUM_TESTS   = 6;
	localparam int FRAME_PIX   = IMAGE_COLS * IMAGE_ROWS;
	localparam int WATCHDOG_NS = (NUM_TESTS + 2) * 1024 * 40;

	logic     clk;
	logic     rst;
	pixel_t   pixel;
	feature_t pool_out [C1_MAPS];
	logic     pool_valid;

	test_row_t tests [NUM_TESTS];
	pixel_t    model_mem [C1_MAPS*(KERNEL_TAPS+1)];  // same layout as the dut memory
	pixel_t    frame_pix [IMAGE_ROWS][IMAGE_COLS];
	logic [31:0] rng;

	// expected s2 results in arrival order
	int exp_due [$];    // cycle index at which pool_valid must be high
	int exp_test [$];
	int exp_pos [$];    // i*S2_SIZE + j
	logic [C1_MAPS-1:0][HALF_WIDTH-1:0] exp_vals [$];

	int frame_hits [NUM_TESTS];
	int neg_idx;        // cycle index where 0 is the negedge after the first pixel edge
	int checked;
	int value_errors;
	int pulse_errors;
	int other_errors;

	lenet_c1s2 DUT (
		.clk        (clk),
		.rst        (rst),
		.pixel      (pixel),
		.pool_out   (pool_out),
		.pool_valid (pool_valid)
	);

	bind lenet_c1s2 lenet_c1s2_assertions u_checks (
		.clk        (clk),
		.rst        (rst),
		.c1_valid   (c1_valid),
		.pool_valid (pool_valid),
		.pool_out   (pool_out)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic fill_frame(input int t);
		int v;
		for (int r = 0; r < IMAGE_ROWS; r++) begin
			for (int c = 0; c < IMAGE_COLS; c++) begin
				case (tests[t].kind)
					kind_const: v = tests[t].value;
					kind_ramp:  v = tests[t].value + r*7 + c*3;  // wraps at 8 bits
					kind_random: begin
						rng = xorshift32(rng);
						v = int'(rng[7:0]);
					end
					default: begin
						rng = xorshift32(rng);
						v = tests[t].value - int'(rng[4:0]);  // stays near -128
					end
				endcase
				frame_pix[r][c] = pixel_t'(v);
			end
		end
	endtask

	// golden c1 maps with 16-bit wrap and relu followed by 2x2 max per s2 position
	task automatic build_expected(input int t);
		int s;
		int base;
		feature_t v;
		feature_t c1 [C1_MAPS][C1_SIZE][C1_SIZE];
		logic [C1_MAPS-1:0][HALF_WIDTH-1:0] vals;
		for (int g = 0; g < C1_MAPS; g++) begin
			base = g_base(g);
			for (int y = 0; y < C1_SIZE; y++) begin
				for (int x = 0; x < C1_SIZE; x++) begin
					s = int'(model_mem[base+KERNEL_TAPS]);
					for (int ky = 0; ky < KERNEL_SIZE; ky++) begin
						for (int kx = 0; kx < KERNEL_SIZE; kx++) begin
							s += int'(frame_pix[y+ky][x+kx]) *
								int'(model_mem[base+ky*KERNEL_SIZE+kx]);
						end
					end
					v = feature_t'(s);  // modulo 2^16
					c1[g][y][x] = (v < 0) ? feature_t'(0) : v;
				end
			end
		end
		for (int i = 0; i < S2_SIZE; i++) begin
			for (int j = 0; j < S2_SIZE; j++) begin
				for (int g = 0; g < C1_MAPS; g++) begin
					v = c1[g][2*i][2*j];
					if (c1[g][2*i][2*j+1] > v) v = c1[g][2*i][2*j+1];
					if (c1[g][2*i+1][2*j] > v) v = c1[g][2*i+1][2*j];
					if (c1[g][2*i+1][2*j+1] > v) v = c1[g][2*i+1][2*j+1];
					vals[g] = v;
				end
				// result shows at the negedge after the edge of pixel (2i+5, 2j+5)
				exp_due.push_back(t*FRAME_PIX + (2*i+5)*IMAGE_COLS + (2*j+5) + 1);
				exp_test.push_back(t);
				exp_pos.push_back(i*S2_SIZE + j);
				exp_vals.push_back(vals);
			end
		end
	endtask

	function automatic int g_base(input int g);
		return g * (KERNEL_TAPS + 1);
	endfunction

	task automatic finish_run();
		$display("summary: %0d checked, %0d value errors, %0d pulse errors, %0d other errors",
			checked, value_errors, pulse_errors, other_errors);
		if (value_errors + pulse_errors + other_errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	endtask

	// sample mid-cycle away from the driving edge
	always @(negedge clk) begin
		if (rst !== 1'b0) begin
			neg_idx = -2;
			if (pool_valid === 1'b1) begin
				other_errors++;
				$display("pool_valid went high during reset");
			end
		end else begin
			neg_idx++;
			while (exp_due.size() > 0 && exp_due[0] < neg_idx) begin
				pulse_errors++;
				$display("missing pool_valid pulse in %s at s2 position %0d",
					tests[exp_test[0]].name, exp_pos[0]);
				void'(exp_due.pop_front());
				void'(exp_test.pop_front());
				void'(exp_pos.pop_front());
				void'(exp_vals.pop_front());
			end
			if (pool_valid !== 1'b0) begin
				if (exp_due.size() == 0 || exp_due[0] != neg_idx) begin
					pulse_errors++;
					$display("unexpected pool_valid pulse at cycle %0d", neg_idx);
				end else begin
					checked++;
					frame_hits[exp_test[0]]++;
					for (int g = 0; g < C1_MAPS; g++) begin
						if (pool_out[g] !== exp_vals[0][g]) begin
							value_errors++;
							$display("ERROR %s map %0d pos %0d: expected %0d, actual %0d",
								tests[exp_test[0]].name, g, exp_pos[0],
								$signed(exp_vals[0][g]), pool_out[g]);
						end
					end
					void'(exp_due.pop_front());
					void'(exp_test.pop_front());
					void'(exp_pos.pop_front());
					void'(exp_vals.pop_front());
				end
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		other_errors++;
		$display("watchdog expired before all frames were checked");
		finish_run();
	end

	initial begin
		rst = 1'b1;
		pixel = '0;
		rng = 32'hc08b;
		neg_idx = -2;
		checked = 0;
		value_errors = 0;
		pulse_errors = 0;
		other_errors = 0;
		$readmemh("kernel_c1.mem", model_mem);
		tests[0] = '{"zero_frame",     kind_const,  0,   196};
		tests[1] = '{"ramp_frame",     kind_ramp,   3,   196};
		tests[2] = '{"random_frame_a", kind_random, 0,   196};
		tests[3] = '{"negative_frame", kind_neg,    -96, 196};
		tests[4] = '{"random_frame_b", kind_random, 0,   196};
		tests[5] = '{"max_frame",      kind_const,  127, 196};
		for (int t = 0; t < NUM_TESTS; t++) begin
			frame_hits[t] = 0;
		end
		repeat (10) @(posedge clk);
		#2;
		rst = 1'b0;
		// model runs in zero time between the last pixel of one frame and the next
		for (int t = 0; t < NUM_TESTS; t++) begin
			fill_frame(t);
			build_expected(t);
			for (int r = 0; r < IMAGE_ROWS; r++) begin
				for (int c = 0; c < IMAGE_COLS; c++) begin
					pixel = frame_pix[r][c];
					@(posedge clk);
					#2;
				end
			end
		end
		while (exp_due.size() != 0) begin
			@(posedge clk);
		end
		repeat (4) @(posedge clk);  // catch a stray trailing pulse
		for (int t = 0; t < NUM_TESTS; t++) begin
			if (frame_hits[t] != tests[t].pulses) begin
				pulse_errors++;
				$display("frame %s gave %0d pool_valid pulses instead of %0d",
					tests[t].name, frame_hits[t], tests[t].pulses);
			end
		end
		finish_run();
	end

endmodule
